// ==== chord_synth.f ====
synth_pkg.sv
note_sequencer.sv
micro_decoder.sv
alu_core.sv
sample_output.sv
chord_synth.sv
tb_chord_synth.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the chord synth testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_chord_synth -f chord_synth.f

result=$(./obj_dir/Vtb_chord_synth)
echo "$result"

if echo "$result" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

// ==== tb_chord_synth.sv ====
// ------------------------------
// chord synth testbench
// stimulus/expected table, note and mix model
// req/ack driver, result checks, watchdog
// ------------------------------
`default_nettype none

module tb_chord_synth;
	import synth_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_SWEEP    = 48; // plain track sweep
	localparam int NUM_SILENCE  = 8;  // PC_SILENCE rows
	localparam int NUM_VARIANT  = 12; // chords_alt / simple_bass at position 3
	localparam int NUM_MOD      = 8;  // modulate rows
	localparam int NUM_RANDOM   = 12;
	localparam int NUM_ENTRIES  = NUM_SWEEP + NUM_SILENCE + NUM_VARIANT + NUM_MOD + NUM_RANDOM;
	localparam int ACK_LATENCY  = PROG_LEN + 2;  // edges from req sampled to ack
	localparam int WAIT_LIMIT   = PROG_LEN + 8;
	localparam int FALL_LIMIT   = 4;
	localparam int WATCHDOG_CYCLES = NUM_ENTRIES * (PROG_LEN + 10) + RESET_CYCLES;
	localparam logic [31:0] SEED = 32'h2ffe0a9c;

	logic                                clk;
	logic                                reset;
	logic                                req;
	logic [SAMPLE_COUNTER_BITS-1:0]      sample_counter;
	logic [CONTROL_BITS-1:0]             control;
	logic                                ack;
	logic signed [A_BITS-1:0]            out;

	// table, expected column filled by the model
	logic [SAMPLE_COUNTER_BITS-1:0] tab_sc   [NUM_ENTRIES];
	logic [CONTROL_BITS-1:0]        tab_ctrl [NUM_ENTRIES];
	logic [A_BITS-1:0]              tab_exp  [NUM_ENTRIES];

	logic [A_BITS-1:0] model_phase_chord; // carried row to row
	logic [A_BITS-1:0] model_phase_bass;
	int                pass_count;
	int                fail_count;
	logic              stop_run;         // handshake broke, no point going on

	// one octave, C down to B
	int mant_values [12] = '{246, 232, 219, 207, 195, 184, 174, 164, 155, 146, 138, 130};

	chord_synth DUT (
		.clk            (clk),
		.reset          (reset),
		.req            (req),
		.sample_counter (sample_counter),
		.control        (control),
		.ack            (ack),
		.out            (out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic note_t pack_note(input int oct, input int idx);
		return {1'b0, OCT_BITS'(oct), NOTE_BITS'(idx)};
	endfunction

	function automatic logic [INC_BITS-1:0] voice_inc(input note_t n, input logic modulate);
		logic [NOTE_BITS-1:0] idx;
		logic [OCT_BITS-1:0]  oct;
		int                   mant;
		idx  = n[NOTE_BITS-1:0] + NOTE_BITS'(modulate); // stays inside the note field
		oct  = n[NOTE_BITS +: OCT_BITS];
		mant = (idx < 12) ? mant_values[idx] : 0;       // 12..15 give zero
		mant = mant % (1 << MANT_BITS);                 // entry keeps MANT_BITS bits
		if (oct == OCT_SILENT)
			return '0;
		return INC_BITS'((mant << (INC_BITS - MANT_BITS)) >> oct);
	endfunction

	function automatic note_t chord_note_of(input logic [SAMPLE_COUNTER_BITS-1:0] sc,
		input logic [CONTROL_BITS-1:0] ctrl);
		logic [1:0] pos;
		logic [SILENCE_CHORD_BITS-1:0] window;
		pos    = sc[TRACK_LOG2_WAIT +: 2];
		window = sc[TRACK_LOG2_WAIT-SILENCE_CHORD_BITS +: SILENCE_CHORD_BITS];
		if (ctrl[PC_SILENCE] || window == 0)
			return pack_note(OCT_SILENT, 0); // rest
		case (pos)
			2'd0: return pack_note(1, 0);
			2'd1: return pack_note(2, 7);
			2'd2: return pack_note(2, 5);
			default: return ctrl[PC_CHORDS_ALT] ? pack_note(2, 1) : pack_note(2, 8);
		endcase
	endfunction

	function automatic note_t bass_note_of(input logic [SAMPLE_COUNTER_BITS-1:0] sc,
		input logic [CONTROL_BITS-1:0] ctrl);
		logic [1:0]  pos;
		logic [3:0]  bpos;
		logic [15:0] play1; // one bit per bass position
		logic [15:0] play2;
		note_t       n1;
		note_t       n2;
		pos  = sc[TRACK_LOG2_WAIT +: 2];
		bpos = sc[BASS_LOG2_WAIT +: 4];
		case (pos)
			2'd0: begin n1 = pack_note(3, 0); n2 = pack_note(3, 7); end
			2'd1: begin n1 = pack_note(3, 2); n2 = pack_note(3, 7); end
			2'd2: begin n1 = pack_note(3, 0); n2 = pack_note(3, 5); end
			default: begin n1 = pack_note(3, 5); n2 = pack_note(3, 8); end
		endcase
		if (ctrl[PC_SIMPLE_BASS]) begin
			play1 = 16'h5115; // 0 2 4 8 12 14
			play2 = 16'h2442; // 1 6 10 13
		end else if (pos == 2'd3) begin
			play1 = 16'h1311; // 0 4 8 9 12
			play2 = 16'h4444; // 2 6 10 14
		end else begin
			play1 = 16'h3135; // 0 2 4 5 8 12 13
			play2 = 16'h4442; // 1 6 10 14
		end
		if (play1[bpos])
			return n1;
		if (play2[bpos])
			return n2;
		return pack_note(OCT_SILENT, 0);
	endfunction

	// one microprogram run: both phases advance, then halved sum with msb flipped
	task automatic model_step(input logic [SAMPLE_COUNTER_BITS-1:0] sc,
		input logic [CONTROL_BITS-1:0] ctrl, output logic [A_BITS-1:0] sample);
		logic [A_BITS-1:0] chord_step;
		logic [A_BITS-1:0] bass_step;
		chord_step = {1'b0, voice_inc(chord_note_of(sc, ctrl), ctrl[PC_MODULATE])};
		bass_step  = {1'b0, voice_inc(bass_note_of(sc, ctrl), ctrl[PC_MODULATE])};
		model_phase_chord = model_phase_chord + chord_step; // mod 2^A_BITS
		model_phase_bass  = model_phase_bass + bass_step;
		sample = ((model_phase_chord >> 1) + (model_phase_bass >> 1)) ^
			{1'b1, {(A_BITS-1){1'b0}}};
	endtask

	task automatic add_row(input int n, input logic [SAMPLE_COUNTER_BITS-1:0] sc,
		input logic [CONTROL_BITS-1:0] ctrl);
		logic [A_BITS-1:0] expected;
		model_step(sc, ctrl, expected);
		tab_sc[n]   = sc;
		tab_ctrl[n] = ctrl;
		tab_exp[n]  = expected;
	endtask

	// ------------------------------
	// table setup
	// ------------------------------
	task automatic build_table();
		int                             n;
		logic [SAMPLE_COUNTER_BITS-1:0] r_sc;
		logic [CONTROL_BITS-1:0]        r_ctrl;
		n = 0;
		model_phase_chord = '0; // DUT phases after reset
		model_phase_bass  = '0;
		for (int i = 0; i < NUM_SWEEP; i++) begin // all positions, rest windows too
			add_row(n, SAMPLE_COUNTER_BITS'(i * 6), '0);
			n++;
		end
		for (int i = 0; i < NUM_SILENCE; i++) begin
			add_row(n, SAMPLE_COUNTER_BITS'(16 + i * 32), CONTROL_BITS'(1 << PC_SILENCE));
			n++;
		end
		for (int i = 0; i < NUM_VARIANT; i++) begin // alt, simple, both
			add_row(n, SAMPLE_COUNTER_BITS'(192 + i * 5), CONTROL_BITS'(2 * (i % 3 + 1)));
			n++;
		end
		for (int i = 0; i < NUM_MOD; i++) begin
			r_ctrl = CONTROL_BITS'(1 << PC_MODULATE);
			if (i % 2 == 1)
				r_ctrl[PC_CHORDS_ALT] = 1'b1;
			add_row(n, SAMPLE_COUNTER_BITS'(40 + i * 28), r_ctrl);
			n++;
		end
		for (int i = 0; i < NUM_RANDOM; i++) begin
			r_sc   = SAMPLE_COUNTER_BITS'($urandom);
			r_ctrl = CONTROL_BITS'($urandom);
			add_row(n, r_sc, r_ctrl);
			n++;
		end
	endtask

	task automatic check_reset_state();
		if (ack !== 1'b0 || out !== '0) begin
			$display("error @%0t: after reset ack=%b out=%h, expected ack=0 out=000",
				$time, ack, out);
			fail_count++;
		end else begin
			$display("ok    reset state");
			pass_count++;
		end
	endtask

	// ------------------------------
	// one req/ack cycle per row
	// ------------------------------
	task automatic run_entry(input int e);
		int                waited;
		int                latency;
		logic [A_BITS-1:0] got;
		waited         = 0;
		sample_counter = tab_sc[e];   // falling edge
		control        = tab_ctrl[e];
		req            = 1'b1;
		do begin
			@(negedge clk);
			waited++;
		end while (!ack && waited < WAIT_LIMIT);
		if (!ack) begin
			$display("entry %0d: the DUT never raised ack within %0d cycles of req",
				e, WAIT_LIMIT);
			fail_count++;
			stop_run = 1'b1;
			req      = 1'b0;
			return;
		end
		latency = waited - 1; // first negedge follows the sampling edge
		got     = out;
		req     = 1'b0;
		waited  = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (ack && waited < FALL_LIMIT);
		if (ack) begin
			$display("entry %0d: ack stayed high after req was dropped", e);
			fail_count++;
			stop_run = 1'b1;
			return;
		end
		if (got !== tab_exp[e]) begin
			$display("error @%0t: entry %0d sc=%h ctrl=%b out=%h expected %h",
				$time, e, tab_sc[e], tab_ctrl[e], got, tab_exp[e]);
			fail_count++;
		end else if (latency != ACK_LATENCY) begin
			$display("error @%0t: entry %0d ack after %0d cycles, expected %0d",
				$time, e, latency, ACK_LATENCY);
			fail_count++;
		end else begin
			$display("ok    entry %0d sc=%h ctrl=%b out=%h", e, tab_sc[e], tab_ctrl[e], got);
			pass_count++;
		end
	endtask

	// main sequence
	initial begin
		void'($urandom(SEED));
		reset          = 1'b1;
		req            = 1'b0;
		sample_counter = '0;
		control        = '0;
		pass_count     = 0;
		fail_count     = 0;
		stop_run       = 1'b0;
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_reset_state();
		for (int e = 0; e < NUM_ENTRIES && !stop_run; e++)
			run_entry(e);
		$display("tests %0d  passed %0d  failed %0d", pass_count + fail_count,
			pass_count, fail_count);
		if (fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog, sized from the table length
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== chord_synth.sv ====
// ------------------------------
// chord synth top level
// ALU control interface
// ------------------------------
`default_nettype none

// decoder to ALU control bundle
interface alu_ctrl_if;
	import synth_pkg::*;

	logic [A_SRC_BITS-1:0] a_src;
	logic [S_SRC_BITS-1:0] s_src;
	logic [NUM_REGS-1:0]   dest_mask;
	logic                  update_acc;
	logic                  clear_acc;

	modport decoder (output a_src, s_src, dest_mask, update_acc, clear_acc);
	modport alu     (input  a_src, s_src, dest_mask, update_acc, clear_acc);
endinterface

module chord_synth (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      req,
	input  logic [synth_pkg::SAMPLE_COUNTER_BITS-1:0] sample_counter,
	input  logic [synth_pkg::CONTROL_BITS-1:0]        control,
	output logic                                      ack,
	output logic signed [synth_pkg::A_BITS-1:0]       out
);
	import synth_pkg::*;

	logic [SAMPLE_COUNTER_BITS-1:0] sample_counter_q; // held for the run
	logic [CONTROL_BITS-1:0]        control_q;
	logic [INC_BITS-1:0]            chord_inc;
	logic [INC_BITS-1:0]            bass_inc;
	logic [A_BITS-1:0]              mix;
	logic                           done;

	alu_ctrl_if ctrl_bus ();

	// decode
	note_sequencer u_notes (
		.sample_counter (sample_counter_q),
		.control        (control_q),
		.chord_inc      (chord_inc),
		.bass_inc       (bass_inc)
	);

	micro_decoder u_decoder (
		.clk               (clk),
		.reset             (reset),
		.req               (req),
		.ack               (ack),
		.sample_counter_in (sample_counter),
		.control_in        (control),
		.ctrl              (ctrl_bus.decoder),
		.busy              (),
		.done              (done),
		.sample_counter_q  (sample_counter_q),
		.control_q         (control_q)
	);

	// execute
	alu_core u_alu (
		.clk       (clk),
		.reset     (reset),
		.ctrl      (ctrl_bus.alu),
		.chord_inc (chord_inc),
		.bass_inc  (bass_inc),
		.mix       (mix)
	);

	// result
	sample_output u_out (
		.clk   (clk),
		.reset (reset),
		.done  (done),
		.req   (req),
		.mix   (mix),
		.out   (out),
		.ack   (ack)
	);

endmodule

`default_nettype wire

// ==== sample_output.sv ====
// ------------------------------
// output sample register
// ack side of req/ack handshake
// ------------------------------
`default_nettype none

module sample_output (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                done,
	input  logic                                req,
	input  logic [synth_pkg::A_BITS-1:0]        mix,
	output logic signed [synth_pkg::A_BITS-1:0] out,
	output logic                                ack
);
	import synth_pkg::*;

	logic load_q; // mix lands the edge after done

	always_ff @(posedge clk) begin
		if (reset) begin
			load_q <= 1'b0;
			out    <= '0;
			ack    <= 1'b0;
		end else begin
			load_q <= done;
			if (load_q) begin
				out <= $signed(mix);
				ack <= 1'b1;            // held while req stays high
			end else if (ack && !req) begin
				ack <= 1'b0;            // source let go
			end
		end
	end

endmodule

`default_nettype wire

// ==== alu_core.sv ====
// ------------------------------
// accumulator ALU
// acc, phase and mix registers
// operand muxes, shifter, adder
// ------------------------------
`default_nettype none

module alu_core (
	input  logic                           clk,
	input  logic                           reset,
	alu_ctrl_if.alu                        ctrl,
	input  logic [synth_pkg::INC_BITS-1:0] chord_inc,
	input  logic [synth_pkg::INC_BITS-1:0] bass_inc,
	output logic [synth_pkg::A_BITS-1:0]   mix
);
	import synth_pkg::*;

	logic [A_BITS-1:0] acc;
	logic [A_BITS-1:0] regs [NUM_REGS]; // phase_chord, phase_bass, mix
	logic [A_BITS-1:0] a_val;
	logic [A_BITS-1:0] s_val;
	logic [A_BITS-1:0] s_op;  // after shifter
	logic [A_BITS-1:0] sum;
	logic              halve;

	assign halve = (ctrl.a_src == A_SHR1);

	// ------------------------------
	// A operand
	// ------------------------------
	always_comb begin
		case (ctrl.a_src)
			A_ZERO:    a_val = '0;
			A_ACC:     a_val = acc;
			A_SHR1:    a_val = acc >> 1;                    // logical, phases unsigned
			A_INV_MSB: a_val = acc ^ {1'b1, {(A_BITS-1){1'b0}}};
			default:   a_val = '0;
		endcase
	end

	// ------------------------------
	// S operand
	// ------------------------------
	always_comb begin
		case (ctrl.s_src)
			S_ZERO:        s_val = '0;
			S_INC_CHORD:   s_val = {1'b0, chord_inc};
			S_INC_BASS:    s_val = {1'b0, bass_inc};
			S_PHASE_CHORD: s_val = regs[REG_PHASE_CHORD];
			S_PHASE_BASS:  s_val = regs[REG_PHASE_BASS];
			S_MIX:         s_val = regs[REG_MIX];
			default:       s_val = '0;
		endcase
	end

	// shifter follows the acc halving so the mix stays balanced
	assign s_op = halve ? (s_val >> 1) : s_val;

	// wraps mod 2^A_BITS, phase overflow is the waveform period
	assign sum = a_val + s_op;

	// accumulator
	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (ctrl.clear_acc) begin
			acc <= '0; // fresh run
		end else if (ctrl.update_acc) begin
			acc <= sum;
		end
	end

	// register file, written from acc before its update
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_REGS; i++) begin
				if (ctrl.dest_mask[i])
					regs[i] <= acc;
			end
		end
	end

	assign mix = regs[REG_MIX];

endmodule

`default_nettype wire

// ==== micro_decoder.sv ====
// ------------------------------
// micro decoder
// request capture and input latch
// step counter, microprogram ROM
// ------------------------------
`default_nettype none

module micro_decoder (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      req,
	input  logic                                      ack,
	input  logic [synth_pkg::SAMPLE_COUNTER_BITS-1:0] sample_counter_in,
	input  logic [synth_pkg::CONTROL_BITS-1:0]        control_in,
	alu_ctrl_if.decoder                               ctrl,
	output logic                                      busy,
	output logic                                      done,
	output logic [synth_pkg::SAMPLE_COUNTER_BITS-1:0] sample_counter_q,
	output logic [synth_pkg::CONTROL_BITS-1:0]        control_q
);
	import synth_pkg::*;

	logic                  start;
	logic                  start_q;  // capture cycle, acc cleared here
	logic                  wait_ack; // run over, hold off until ack seen
	logic [STEP_BITS-1:0]  step;
	logic [A_SRC_BITS-1:0] a_src;
	logic [S_SRC_BITS-1:0] s_src;
	logic [NUM_REGS-1:0]   dest_mask;
	logic                  update_acc;

	assign start = req && !ack && !busy && !start_q && !wait_ack;
	assign done  = busy && (step == STEP_BITS'(PROG_LEN-1)); // last step

	// ------------------------------
	// sequencing
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			start_q  <= 1'b0;
			busy     <= 1'b0;
			wait_ack <= 1'b0;
			step     <= '0;
		end else begin
			start_q <= start;
			if (start_q) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 1'b1;
				if (done) begin
					busy     <= 1'b0;
					wait_ack <= 1'b1;
				end
			end
			if (wait_ack && ack)
				wait_ack <= 1'b0; // ack low again before next start
		end
	end

	// inputs held for the whole run
	always_ff @(posedge clk) begin
		if (start) begin
			sample_counter_q <= sample_counter_in;
			control_q        <= control_in;
		end
	end

	// program ROM
	always_comb begin
		a_src      = A_ACC;
		s_src      = S_ZERO;
		dest_mask  = '0;
		update_acc = 1'b1;
		case (step)
			STEP_LOAD_CHORD: s_src = S_INC_CHORD;  // acc cleared at capture
			STEP_ADD_CHORD:  s_src = S_PHASE_CHORD;
			STEP_LOAD_BASS: begin
				a_src = A_ZERO;
				s_src = S_INC_BASS;
				dest_mask[REG_PHASE_CHORD] = 1'b1; // store new chord phase
			end
			STEP_ADD_BASS:   s_src = S_PHASE_BASS;
			STEP_MIX_CHORD: begin
				a_src = A_ZERO;
				s_src = S_PHASE_CHORD;
				dest_mask[REG_PHASE_BASS] = 1'b1;
			end
			STEP_MIX_BASS: begin
				a_src = A_SHR1; // chord/2 + bass/2
				s_src = S_PHASE_BASS;
			end
			STEP_INV_MSB:    a_src = A_INV_MSB; // to offset binary
			STEP_STORE_MIX: begin
				update_acc = 1'b0;
				dest_mask[REG_MIX] = 1'b1;
			end
			default:         update_acc = 1'b0;
		endcase
	end

	assign ctrl.a_src      = a_src;
	assign ctrl.s_src      = s_src;
	assign ctrl.dest_mask  = busy ? dest_mask : '0; // idle writes nothing
	assign ctrl.update_acc = busy && update_acc;
	assign ctrl.clear_acc  = start_q;

endmodule

`default_nettype wire

// ==== note_sequencer.sv ====
// ------------------------------
// note sequencer
// chord and bass note per track position
// bass rhythm, modulate, chord silence
// mantissa lookup into phase increments
// ------------------------------
`default_nettype none

module note_sequencer (
	input  logic [synth_pkg::SAMPLE_COUNTER_BITS-1:0] sample_counter,
	input  logic [synth_pkg::CONTROL_BITS-1:0]        control,
	output logic [synth_pkg::INC_BITS-1:0]            chord_inc,
	output logic [synth_pkg::INC_BITS-1:0]            bass_inc
);
	import synth_pkg::*;

	// one octave of mantissas, top entries unused
	function automatic logic [MANT_BITS-1:0] mantissa(input logic [NOTE_BITS-1:0] idx);
		logic [7:0] entry; // table values in 8 bits
		case (idx)
			4'd0:    entry = 8'd246;
			4'd1:    entry = 8'd232;
			4'd2:    entry = 8'd219;
			4'd3:    entry = 8'd207;
			4'd4:    entry = 8'd195;
			4'd5:    entry = 8'd184;
			4'd6:    entry = 8'd174;
			4'd7:    entry = 8'd164;
			4'd8:    entry = 8'd155;
			4'd9:    entry = 8'd146;
			4'd10:   entry = 8'd138;
			4'd11:   entry = 8'd130;
			default: entry = '0;   // 12..15 silent
		endcase
		return entry[MANT_BITS-1:0]; // msb dropped by the 7 bit entry
	endfunction

	// note to phase increment, octave shifts down
	function automatic logic [INC_BITS-1:0] note_inc(input note_t n, input logic modulate);
		logic [NOTE_BITS-1:0] idx;
		logic [OCT_BITS-1:0]  oct;
		logic [INC_BITS-1:0]  full;
		idx  = n[NOTE_BITS-1:0] + NOTE_BITS'(modulate); // no carry into octave
		oct  = n[NOTE_BITS +: OCT_BITS];
		full = {mantissa(idx), {(INC_BITS-MANT_BITS){1'b0}}};
		if (oct == OCT_SILENT)
			return '0;
		return full >> oct;
	endfunction

	localparam note_t NOTE_REST = {1'b0, OCT_SILENT, 4'h0};

	logic [TRACK_POS_BITS-1:0] track_pos;
	logic [BASS_POS_BITS-1:0]  bass_pos;
	logic                      chord_rest;
	note_t                     chord_note;
	note_t                     bass_note;
	note_t                     bass_note1;
	note_t                     bass_note2;

	assign track_pos  = sample_counter[TRACK_LOG2_WAIT +: TRACK_POS_BITS];
	assign bass_pos   = sample_counter[BASS_LOG2_WAIT +: BASS_POS_BITS];
	assign chord_rest = (sample_counter[TRACK_LOG2_WAIT-1 -: SILENCE_CHORD_BITS] == '0) ||
		control[PC_SILENCE]; // rest at start of each position, or muted

	// chord voice
	always_comb begin
		case (track_pos)
			2'd0: chord_note = 8'h10;                                   // C1
			2'd1: chord_note = 8'h27;                                   // G
			2'd2: chord_note = 8'h25;                                   // F
			default: chord_note = control[PC_CHORDS_ALT] ? 8'h21 : 8'h28; // Db / Ab
		endcase
		if (chord_rest)
			chord_note = NOTE_REST;
	end

	// bass note pair per track position
	always_comb begin
		case (track_pos)
			2'd0: begin bass_note1 = 8'h30; bass_note2 = 8'h37; end
			2'd1: begin bass_note1 = 8'h32; bass_note2 = 8'h37; end
			2'd2: begin bass_note1 = 8'h30; bass_note2 = 8'h35; end
			default: begin bass_note1 = 8'h35; bass_note2 = 8'h38; end
		endcase
	end

	// ------------------------------
	// bass rhythm
	// ------------------------------
	always_comb begin
		bass_note = NOTE_REST; // gaps rest
		if (control[PC_SIMPLE_BASS]) begin
			case (bass_pos)
				0, 2, 4, 8, 12, 14: bass_note = bass_note1;
				1, 6, 10, 13:       bass_note = bass_note2;
				default:            bass_note = NOTE_REST;
			endcase
		end else if (track_pos == 2'd3) begin
			case (bass_pos)
				0, 4, 8, 9, 12: bass_note = bass_note1;
				2, 6, 10, 14:   bass_note = bass_note2;
				default:        bass_note = NOTE_REST;
			endcase
		end else begin
			case (bass_pos)
				0, 2, 4, 5, 8, 12, 13: bass_note = bass_note1;
				1, 6, 10, 14:          bass_note = bass_note2;
				default:               bass_note = NOTE_REST;
			endcase
		end
	end

	assign chord_inc = note_inc(chord_note, control[PC_MODULATE]);
	assign bass_inc  = note_inc(bass_note, control[PC_MODULATE]);

endmodule

`default_nettype wire

// ==== synth_pkg.sv ====
// ------------------------------
// chord synth shared package
// widths, control bits, track timing
// ALU source codes, register indices
// microprogram step codes, note_t
// ------------------------------
`default_nettype none

package synth_pkg;

	// datapath widths
	localparam int A_BITS    = 12;          // ALU word
	localparam int INC_BITS  = A_BITS - 1;  // phase increment
	localparam int OCT_BITS  = 3;
	localparam int NOTE_BITS = 4;
	localparam int MANT_BITS = 7;

	localparam logic [OCT_BITS-1:0] OCT_SILENT = 3'd7; // all ones = voice off

	// track timing, all in sample counter bits
	localparam int SAMPLE_COUNTER_BITS = 12;
	localparam int TRACK_POS_BITS      = 2;
	localparam int TRACK_LOG2_WAIT     = 6;
	localparam int BASS_POS_BITS       = 4;
	localparam int BASS_LOG2_WAIT      = TRACK_LOG2_WAIT - BASS_POS_BITS;
	localparam int SILENCE_CHORD_BITS  = 3; // chord rest window below track pos

	// player control bits
	localparam int CONTROL_BITS   = 4;
	localparam int PC_SILENCE     = 0;
	localparam int PC_CHORDS_ALT  = 1;
	localparam int PC_SIMPLE_BASS = 2;
	localparam int PC_MODULATE    = 3;

	// ------------------------------
	// ALU operand sources
	// ------------------------------
	localparam int A_SRC_BITS = 2;
	localparam logic [A_SRC_BITS-1:0] A_ZERO    = 2'd0;
	localparam logic [A_SRC_BITS-1:0] A_ACC     = 2'd1;
	localparam logic [A_SRC_BITS-1:0] A_SHR1    = 2'd2; // acc and S both halved
	localparam logic [A_SRC_BITS-1:0] A_INV_MSB = 2'd3;

	localparam int S_SRC_BITS = 3;
	localparam logic [S_SRC_BITS-1:0] S_ZERO        = 3'd0;
	localparam logic [S_SRC_BITS-1:0] S_INC_CHORD   = 3'd1;
	localparam logic [S_SRC_BITS-1:0] S_INC_BASS    = 3'd2;
	localparam logic [S_SRC_BITS-1:0] S_PHASE_CHORD = 3'd3;
	localparam logic [S_SRC_BITS-1:0] S_PHASE_BASS  = 3'd4;
	localparam logic [S_SRC_BITS-1:0] S_MIX         = 3'd5;

	// register file, one dest_mask bit each
	localparam int REG_PHASE_CHORD = 0;
	localparam int REG_PHASE_BASS  = 1;
	localparam int REG_MIX         = 2;
	localparam int NUM_REGS        = 3;

	// ------------------------------
	// microprogram steps
	// ------------------------------
	localparam int PROG_LEN  = 8;
	localparam int STEP_BITS = 3;
	localparam logic [STEP_BITS-1:0] STEP_LOAD_CHORD = 3'd0;
	localparam logic [STEP_BITS-1:0] STEP_ADD_CHORD  = 3'd1;
	localparam logic [STEP_BITS-1:0] STEP_LOAD_BASS  = 3'd2;
	localparam logic [STEP_BITS-1:0] STEP_ADD_BASS   = 3'd3;
	localparam logic [STEP_BITS-1:0] STEP_MIX_CHORD  = 3'd4;
	localparam logic [STEP_BITS-1:0] STEP_MIX_BASS   = 3'd5;
	localparam logic [STEP_BITS-1:0] STEP_INV_MSB    = 3'd6;
	localparam logic [STEP_BITS-1:0] STEP_STORE_MIX  = 3'd7;

	// octave in [6:4], note index in [3:0]
	typedef logic [7:0] note_t;

endpackage

`default_nettype wire
